//--- src/soc_bus_pkg.sv
package soc_bus_pkg;

  // Bus widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int SEL_W  = DATA_W / 8;  // One select per byte lane
  localparam int GPIO_W = 8;

  typedef logic [ADDR_W-1:0] addr_t;    // Byte address
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [SEL_W-1:0]  sel_t;
  typedef logic [GPIO_W-1:0] gpio_t;
  typedef logic [1:0]        reg_idx_t; // Word inside a peripheral window

  // Memory map
  localparam addr_t GPIO_BASE  = 32'h1000_0000;
  localparam addr_t TIMER_BASE = 32'h1002_0000;

  localparam int unsigned PERIPH_WIN_BYTES = 16;

  // GPIO register map
  localparam reg_idx_t GPIO_OUT_IDX = 2'd0;
  localparam reg_idx_t GPIO_DIR_IDX = 2'd1;
  localparam reg_idx_t GPIO_IN_IDX  = 2'd2;  // Read only

  // Timer register map
  localparam reg_idx_t TMR_COUNT_IDX = 2'd0;  // Read only
  localparam reg_idx_t TMR_CTRL_IDX  = 2'd1;
  localparam reg_idx_t TMR_CMP_IDX   = 2'd2;
  localparam reg_idx_t TMR_STAT_IDX  = 2'd3;

  // True when adr falls inside the window that starts at base
  function automatic logic in_window(
    input addr_t adr,
    input addr_t base
  );
    addr_t offset;
    offset = adr - base;
    return (adr >= base) && (offset < addr_t'(PERIPH_WIN_BYTES));
  endfunction

  // Word index from byte address bits 3:2
  function automatic reg_idx_t reg_idx(
    input addr_t adr
  );
    return adr[3:2];
  endfunction

endpackage

//--- src/wb_if.sv
`timescale 1ns/1ps

interface wb_if;
  import soc_bus_pkg::*;

  // Request side driven by the fabric
  addr_t adr;
  data_t dat_m;
  sel_t  sel;
  logic  stb;    // Already qualified with cyc and the address decode
  logic  we;

  // Response side driven by the peripheral
  data_t dat_s;
  logic  ack;
  logic  err;

  modport master (
    output adr,
    output dat_m,
    output sel,
    output stb,
    output we,
    input  dat_s,
    input  ack,
    input  err
  );

  modport slave (
    input  adr,
    input  dat_m,
    input  sel,
    input  stb,
    input  we,
    output dat_s,
    output ack,
    output err
  );

endinterface

//--- src/wb_gpio_port.sv
`timescale 1ns/1ps

module wb_gpio_port (
  input  logic               sys_clk,
  input  logic               reset_i,
  wb_if.slave                bus,
  input  soc_bus_pkg::gpio_t gpio_in_i,
  output soc_bus_pkg::gpio_t gpio_out_o,
  output soc_bus_pkg::gpio_t gpio_oe_o
);
  import soc_bus_pkg::*;

  gpio_t    out_q;
  gpio_t    dir_q;     // 1 drives the pin
  gpio_t    in_meta_q;
  gpio_t    in_q;
  logic     ack_q;
  data_t    rdata_q;
  data_t    rdata;
  reg_idx_t idx;
  logic     wr_lane0;

  assign idx      = reg_idx(bus.adr);
  assign wr_lane0 = bus.stb & bus.we & bus.sel[0];  // Registers live in byte 0

  // Control registers
  always_ff @(posedge sys_clk) begin
    if (reset_i) begin
      out_q <= '0;
      dir_q <= '0;
    end else if (wr_lane0) begin
      if (idx == GPIO_OUT_IDX) begin
        out_q <= bus.dat_m[GPIO_W-1:0];
      end
      if (idx == GPIO_DIR_IDX) begin
        dir_q <= bus.dat_m[GPIO_W-1:0];
      end
    end
  end

  // Two-stage pin synchronizer whose second stage is the IN register
  always_ff @(posedge sys_clk) begin
    in_meta_q <= gpio_in_i;
    in_q      <= in_meta_q;
  end

  always_comb begin
    case (idx)
      GPIO_OUT_IDX: rdata = data_t'(out_q);
      GPIO_DIR_IDX: rdata = data_t'(dir_q);
      GPIO_IN_IDX:  rdata = data_t'(in_q);
      default:      rdata = '0;
    endcase
  end

  // One-cycle response
  always_ff @(posedge sys_clk) begin
    if (reset_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= bus.stb;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (bus.stb) begin
      rdata_q <= rdata;
    end
  end

  assign bus.ack   = ack_q;
  assign bus.dat_s = rdata_q;
  assign bus.err   = 1'b0;  // Every word in the window answers

  assign gpio_out_o = out_q;
  assign gpio_oe_o  = dir_q;

endmodule

//--- src/wb_timer.sv
`timescale 1ns/1ps

module wb_timer (
  input  logic sys_clk,
  input  logic reset_i,
  wb_if.slave  bus,
  output logic timer_irq_o
);
  import soc_bus_pkg::*;

  data_t    count_q;
  data_t    cmp_q;
  logic     enable_q;  // CTRL bit 0
  logic     match_q;   // Sticky STATUS bit 0
  logic     ack_q;
  data_t    rdata_q;
  data_t    rdata;
  reg_idx_t idx;
  logic     wr_en;
  logic     match_clr;

  assign idx   = reg_idx(bus.adr);
  assign wr_en = bus.stb & bus.we;

  // Write-one-to-clear on STATUS bit 0
  assign match_clr = wr_en & (idx == TMR_STAT_IDX) & bus.sel[0] & bus.dat_m[0];

  always_ff @(posedge sys_clk) begin
    if (reset_i) begin
      count_q <= '0;
    end else if (enable_q) begin
      count_q <= count_q + 1'b1;  // Wraps around and ignores COUNT writes
    end
  end

  always_ff @(posedge sys_clk) begin
    if (reset_i) begin
      enable_q <= 1'b0;
    end else if (wr_en && idx == TMR_CTRL_IDX && bus.sel[0]) begin
      enable_q <= bus.dat_m[0];
    end
  end

  // Compare register with independent byte lanes
  always_ff @(posedge sys_clk) begin
    if (reset_i) begin
      cmp_q <= '0;
    end else if (wr_en && idx == TMR_CMP_IDX) begin
      for (int b = 0; b < SEL_W; b++) begin
        if (bus.sel[b]) begin
          cmp_q[8*b +: 8] <= bus.dat_m[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge sys_clk) begin
    if (reset_i) begin
      match_q <= 1'b0;
    end else if (enable_q && count_q == cmp_q) begin
      match_q <= 1'b1;  // New match wins over a clear in the same cycle
    end else if (match_clr) begin
      match_q <= 1'b0;
    end
  end

  always_comb begin
    case (idx)
      TMR_COUNT_IDX: rdata = count_q;
      TMR_CTRL_IDX:  rdata = data_t'(enable_q);
      TMR_CMP_IDX:   rdata = cmp_q;
      default:       rdata = data_t'(match_q);  // TMR_STAT_IDX
    endcase
  end

  always_ff @(posedge sys_clk) begin
    if (reset_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= bus.stb;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (bus.stb) begin
      rdata_q <= rdata;
    end
  end

  assign bus.ack   = ack_q;
  assign bus.dat_s = rdata_q;
  assign bus.err   = 1'b0;

  assign timer_irq_o = match_q;  // Level interrupt

endmodule

//--- src/wb_shared_bus.sv
`timescale 1ns/1ps

module wb_shared_bus (
  input  logic               sys_clk,
  input  logic               reset_i,

  // Upstream pipelined Wishbone slave port
  input  soc_bus_pkg::addr_t wb_adr_i,
  input  soc_bus_pkg::data_t wb_dat_i,
  input  soc_bus_pkg::sel_t  wb_sel_i,
  input  logic               wb_cyc_i,
  input  logic               wb_stb_i,
  input  logic               wb_we_i,
  output soc_bus_pkg::data_t wb_dat_o,
  output logic               wb_ack_o,
  output logic               wb_err_o,

  // Downstream peripheral buses
  wb_if.master               gpio_bus,
  wb_if.master               timer_bus
);
  import soc_bus_pkg::*;

  logic req;
  logic gpio_hit;
  logic timer_hit;
  logic unmapped_err_q;

  assign req = wb_cyc_i & wb_stb_i;  // Accepted on this edge since stall never rises

  // Address decode
  assign gpio_hit  = in_window(wb_adr_i, GPIO_BASE);
  assign timer_hit = in_window(wb_adr_i, TIMER_BASE);

  // Request fields go to both peripherals and only the strobe is steered
  assign gpio_bus.adr   = wb_adr_i;
  assign gpio_bus.dat_m = wb_dat_i;
  assign gpio_bus.sel   = wb_sel_i;
  assign gpio_bus.we    = wb_we_i;
  assign gpio_bus.stb   = req & gpio_hit;

  assign timer_bus.adr   = wb_adr_i;
  assign timer_bus.dat_m = wb_dat_i;
  assign timer_bus.sel   = wb_sel_i;
  assign timer_bus.we    = wb_we_i;
  assign timer_bus.stb   = req & timer_hit;

  // An unclaimed address gets an error one cycle later
  always_ff @(posedge sys_clk) begin
    if (reset_i) begin
      unmapped_err_q <= 1'b0;
    end else begin
      unmapped_err_q <= req & ~gpio_hit & ~timer_hit;
    end
  end

  // Response merge
  // At most one target answers per cycle since one request is issued per cycle
  assign wb_ack_o = gpio_bus.ack | timer_bus.ack;
  assign wb_err_o = gpio_bus.err | timer_bus.err | unmapped_err_q;

  always_comb begin
    if (gpio_bus.ack) begin
      wb_dat_o = gpio_bus.dat_s;
    end else if (timer_bus.ack) begin
      wb_dat_o = timer_bus.dat_s;
    end else begin
      wb_dat_o = '0;  // Quiet bus when nothing acknowledges
    end
  end

endmodule

//--- src/periph_subsystem_top.sv
`timescale 1ns/1ps

module periph_subsystem_top (
  input  logic               sys_clk,
  input  logic               reset_i,

  // Pipelined Wishbone slave port
  input  soc_bus_pkg::addr_t wb_adr_i,
  input  soc_bus_pkg::data_t wb_dat_i,
  input  soc_bus_pkg::sel_t  wb_sel_i,
  input  logic               wb_cyc_i,
  input  logic               wb_stb_i,
  input  logic               wb_we_i,
  output soc_bus_pkg::data_t wb_dat_o,
  output logic               wb_ack_o,
  output logic               wb_err_o,
  output logic               wb_stall_o,

  // GPIO pins
  input  soc_bus_pkg::gpio_t gpio_in_i,
  output soc_bus_pkg::gpio_t gpio_out_o,
  output soc_bus_pkg::gpio_t gpio_oe_o,

  output logic               timer_irq_o
);

  wb_if gpio_bus ();
  wb_if timer_bus ();

  // Neither peripheral back-pressures
  assign wb_stall_o = 1'b0;

  wb_shared_bus u_wb_shared_bus (
    .sys_clk   (sys_clk),
    .reset_i   (reset_i),
    .wb_adr_i  (wb_adr_i),
    .wb_dat_i  (wb_dat_i),
    .wb_sel_i  (wb_sel_i),
    .wb_cyc_i  (wb_cyc_i),
    .wb_stb_i  (wb_stb_i),
    .wb_we_i   (wb_we_i),
    .wb_dat_o  (wb_dat_o),
    .wb_ack_o  (wb_ack_o),
    .wb_err_o  (wb_err_o),
    .gpio_bus  (gpio_bus.master),
    .timer_bus (timer_bus.master)
  );

  wb_gpio_port u_wb_gpio_port (
    .sys_clk    (sys_clk),
    .reset_i    (reset_i),
    .bus        (gpio_bus.slave),
    .gpio_in_i  (gpio_in_i),
    .gpio_out_o (gpio_out_o),
    .gpio_oe_o  (gpio_oe_o)
  );

  wb_timer u_wb_timer (
    .sys_clk     (sys_clk),
    .reset_i     (reset_i),
    .bus         (timer_bus.slave),
    .timer_irq_o (timer_irq_o)
  );

endmodule

//--- dv/periph_subsystem_props.sv
`timescale 1ns/1ps

module periph_subsystem_props (
  input logic sys_clk,
  input logic reset_i,
  input logic wb_cyc_i,
  input logic wb_stb_i,
  input logic wb_ack_o,
  input logic wb_err_o,
  input logic wb_stall_o
);

  logic req;

  assign req = wb_cyc_i & wb_stb_i;  // Stall is never raised, so this is an accepted request

  // One response kind per cycle
  ack_err_excl: assert property (@(posedge sys_clk) disable iff (reset_i)
    !(wb_ack_o && wb_err_o))
    else $error("ack and err are high in the same cycle");

  resp_next_cycle: assert property (@(posedge sys_clk) disable iff (reset_i)
    req |=> (wb_ack_o || wb_err_o))
    else $error("accepted request got no ack or err in the next cycle");

  stall_low: assert property (@(posedge sys_clk) disable iff (reset_i)
    !wb_stall_o)
    else $error("stall went high");

  // Responses only follow a request
  no_orphan_resp: assert property (@(posedge sys_clk) disable iff (reset_i)
    (wb_ack_o || wb_err_o) |-> $past(req))
    else $error("response without a request in the previous cycle");

endmodule

bind periph_subsystem_top periph_subsystem_props u_periph_subsystem_props (
  .sys_clk    (sys_clk),
  .reset_i    (reset_i),
  .wb_cyc_i   (wb_cyc_i),
  .wb_stb_i   (wb_stb_i),
  .wb_ack_o   (wb_ack_o),
  .wb_err_o   (wb_err_o),
  .wb_stall_o (wb_stall_o)
);

//--- dv/tb_periph_subsystem.sv
`timescale 1ns/1ps

module tb_periph_subsystem;
  import soc_bus_pkg::*;

  localparam int RESP_LIMIT = 16;  // Cycles allowed for one response
  localparam int POLL_LIMIT = 80;

  // Register addresses are the word index times four
  localparam addr_t GPIO_OUT_A = GPIO_BASE + 32'h0;
  localparam addr_t GPIO_DIR_A = GPIO_BASE + 32'h4;
  localparam addr_t GPIO_IN_A  = GPIO_BASE + 32'h8;
  localparam addr_t TMR_CNT_A  = TIMER_BASE + 32'h0;
  localparam addr_t TMR_CTRL_A = TIMER_BASE + 32'h4;
  localparam addr_t TMR_CMP_A  = TIMER_BASE + 32'h8;
  localparam addr_t TMR_STAT_A = TIMER_BASE + 32'hC;

  typedef enum int {
    OP_WR, OP_RD, OP_POLL, OP_PINS, OP_DRIVE, OP_HOLD, OP_RISE, OP_PIPE_WR, OP_PIPE_RD
  } op_e;

  typedef struct {
    op_e   op;
    addr_t adr;
    data_t wdat;
    sel_t  sel;
    data_t exp;      // Read data or {irq, oe, out} for OP_PINS
    logic  exp_err;
    int    test;
  } entry_t;

  logic  sys_clk;
  logic  reset_i;
  addr_t wb_adr_i;
  data_t wb_dat_i;
  sel_t  wb_sel_i;
  logic  wb_cyc_i;
  logic  wb_stb_i;
  logic  wb_we_i;
  data_t wb_dat_o;
  logic  wb_ack_o;
  logic  wb_err_o;
  logic  wb_stall_o;
  gpio_t gpio_in_i;
  gpio_t gpio_out_o;
  gpio_t gpio_oe_o;
  logic  timer_irq_o;

  entry_t table_q[$];
  int     errors;
  int     checks;
  int     tests_run;

  periph_subsystem_top u_periph_subsystem_top (.*);

  initial begin
    sys_clk = 1'b0;
    forever #5 sys_clk = ~sys_clk;
  end

  task automatic check(input data_t got, input data_t exp, input string msg);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0d ns: %s, got %h expected %h", $time, msg, got, exp);
    end
  endtask

  task automatic add_entry(input op_e op, input addr_t adr, input data_t wdat, input sel_t sel,
                           input data_t exp, input logic exp_err, input int test);
    entry_t e;
    e = '{op, adr, wdat, sel, exp, exp_err, test};
    table_q.push_back(e);
  endtask

  function automatic logic is_pipe(input op_e op);
    return (op == OP_PIPE_WR) || (op == OP_PIPE_RD);
  endfunction

  // Single request followed by a wait for its response
  task automatic bus_access(input logic we, input addr_t adr, input data_t wdat, input sel_t sel,
                            output data_t rdat, output logic ack, output logic err,
                            output logic done);
    int n;
    @(negedge sys_clk);
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = adr;
    wb_dat_i = wdat;
    wb_sel_i = sel;
    @(negedge sys_clk);
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    n = 0;
    while (!(wb_ack_o || wb_err_o) && n < RESP_LIMIT) begin
      @(negedge sys_clk);
      n++;
    end
    done = wb_ack_o || wb_err_o;
    rdat = wb_dat_o;
    ack  = wb_ack_o;
    err  = wb_err_o;
    if (!done) begin
      errors++;
      $display("Timed out at %0d ns: no ack or err within %0d cycles for address %h",
               $time, RESP_LIMIT, adr);
    end
  endtask

  task automatic check_resp(input entry_t e, input data_t rdat, input logic ack, input logic err);
    check(data_t'(err), data_t'(e.exp_err), $sformatf("err for %h", e.adr));
    check(data_t'(ack), data_t'(!e.exp_err), $sformatf("ack for %h", e.adr));
    check(data_t'(wb_stall_o), 32'd0, $sformatf("stall around %h", e.adr));
    if ((e.op == OP_RD || e.op == OP_PIPE_RD) && !e.exp_err) begin
      check(rdat, e.exp, $sformatf("read data from %h", e.adr));
    end
  endtask

  task automatic apply_entry(input entry_t e);
    data_t rdat;
    data_t first;
    data_t second;
    logic  ack;
    logic  err;
    logic  done;
    int    n;
    case (e.op)
      OP_WR, OP_RD: begin
        bus_access(e.op == OP_WR, e.adr, e.wdat, e.sel, rdat, ack, err, done);
        if (done) check_resp(e, rdat, ack, err);
      end
      OP_POLL: begin  // Keep reading while the synchronizer or timer catches up
        n    = 0;
        done = 1'b1;
        rdat = ~e.exp;
        while (done && rdat !== e.exp && n < POLL_LIMIT) begin
          bus_access(1'b0, e.adr, '0, 4'hF, rdat, ack, err, done);
          n++;
        end
        if (done && rdat !== e.exp) begin
          $display("Timed out: %h did not read %h within %0d reads", e.adr, e.exp, n);
        end
        if (done) check(rdat, e.exp, $sformatf("polled value of %h", e.adr));
      end
      OP_PINS: begin
        @(negedge sys_clk);
        check(data_t'({timer_irq_o, gpio_oe_o, gpio_out_o}), e.exp, "irq, oe and out pins");
      end
      OP_DRIVE: begin
        @(negedge sys_clk);
        gpio_in_i = e.wdat[GPIO_W-1:0];
      end
      OP_HOLD: begin  // Read, try to overwrite, read again
        bus_access(1'b0, e.adr, '0, 4'hF, first, ack, err, done);
        if (done) bus_access(1'b1, e.adr, e.wdat, 4'hF, rdat, ack, err, done);
        if (done) bus_access(1'b0, e.adr, '0, 4'hF, second, ack, err, done);
        if (done) check(second, first, "COUNT holds and ignores writes");
      end
      OP_RISE: begin
        bus_access(1'b0, e.adr, '0, 4'hF, first, ack, err, done);
        if (done) bus_access(1'b0, e.adr, '0, 4'hF, second, ack, err, done);
        if (done) check(data_t'(second > first), 32'd1, "COUNT advances while enabled");
      end
      default: begin
        errors++;
        $display("Table entry with an operation the loop cannot apply");
      end
    endcase
  endtask

  // Back-to-back strobes with each response due in the very next cycle
  task automatic run_burst(input int first, input int last);
    entry_t e;
    for (int k = first; k <= last + 1; k++) begin
      @(negedge sys_clk);
      if (k > first) begin
        e = table_q[k - 1];
        if (!(wb_ack_o || wb_err_o)) begin
          errors++;
          $display("No response at %0d ns for burst request to %h", $time, e.adr);
        end else begin
          check_resp(e, wb_dat_o, wb_ack_o, wb_err_o);
        end
      end
      if (k <= last) begin
        e = table_q[k];
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = (e.op == OP_PIPE_WR);
        wb_adr_i = e.adr;
        wb_dat_i = e.wdat;
        wb_sel_i = e.sel;
      end else begin
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
      end
    end
  endtask

  task automatic build_table();
    // Reset state
    add_entry(OP_PINS, '0, '0, 4'h0, 32'h0, 1'b0, 1);
    add_entry(OP_RD, GPIO_OUT_A, '0, 4'hF, 32'h0, 1'b0, 1);
    add_entry(OP_RD, GPIO_DIR_A, '0, 4'hF, 32'h0, 1'b0, 1);
    add_entry(OP_RD, GPIO_IN_A, '0, 4'hF, 32'h0, 1'b0, 1);
    add_entry(OP_RD, TMR_CNT_A, '0, 4'hF, 32'h0, 1'b0, 1);
    add_entry(OP_RD, TMR_CTRL_A, '0, 4'hF, 32'h0, 1'b0, 1);
    add_entry(OP_RD, TMR_CMP_A, '0, 4'hF, 32'h0, 1'b0, 1);
    add_entry(OP_RD, TMR_STAT_A, '0, 4'hF, 32'h0, 1'b0, 1);
    // GPIO registers
    add_entry(OP_WR, GPIO_OUT_A, 32'hA5, 4'h1, '0, 1'b0, 2);
    add_entry(OP_WR, GPIO_DIR_A, 32'h0F, 4'h1, '0, 1'b0, 2);
    add_entry(OP_RD, GPIO_OUT_A, '0, 4'hF, 32'hA5, 1'b0, 2);
    add_entry(OP_RD, GPIO_DIR_A, '0, 4'hF, 32'h0F, 1'b0, 2);
    add_entry(OP_PINS, '0, '0, 4'h0, 32'h0FA5, 1'b0, 2);
    add_entry(OP_WR, GPIO_OUT_A, 32'h11, 4'hE, '0, 1'b0, 2);  // Lane 0 off
    add_entry(OP_RD, GPIO_OUT_A, '0, 4'hF, 32'hA5, 1'b0, 2);
    add_entry(OP_WR, GPIO_IN_A, 32'hFF, 4'hF, '0, 1'b0, 2);
    add_entry(OP_RD, GPIO_IN_A, '0, 4'hF, 32'h0, 1'b0, 2);
    // GPIO input through the synchronizer
    add_entry(OP_DRIVE, '0, 32'h5A, 4'h0, '0, 1'b0, 3);
    add_entry(OP_POLL, GPIO_IN_A, '0, 4'hF, 32'h5A, 1'b0, 3);
    add_entry(OP_DRIVE, '0, 32'hC3, 4'h0, '0, 1'b0, 3);
    add_entry(OP_POLL, GPIO_IN_A, '0, 4'hF, 32'hC3, 1'b0, 3);
    // Timer counting with compare parked out of reach
    add_entry(OP_WR, TMR_CMP_A, 32'hFFFF_FF00, 4'hF, '0, 1'b0, 4);
    add_entry(OP_HOLD, TMR_CNT_A, 32'h1234_5678, 4'hF, '0, 1'b0, 4);
    add_entry(OP_WR, TMR_CTRL_A, 32'h1, 4'h1, '0, 1'b0, 4);
    add_entry(OP_RISE, TMR_CNT_A, '0, 4'hF, '0, 1'b0, 4);
    add_entry(OP_WR, TMR_CTRL_A, 32'h0, 4'h1, '0, 1'b0, 4);
    add_entry(OP_HOLD, TMR_CNT_A, 32'h0, 4'hF, '0, 1'b0, 4);
    // Match and interrupt
    add_entry(OP_WR, TMR_CMP_A, 32'h0000_0040, 4'hE, '0, 1'b0, 5);  // Upper lanes only
    add_entry(OP_WR, TMR_CMP_A, 32'hFFFF_FF40, 4'h1, '0, 1'b0, 5);
    add_entry(OP_RD, TMR_CMP_A, '0, 4'hF, 32'h40, 1'b0, 5);
    add_entry(OP_WR, TMR_CTRL_A, 32'h1, 4'h1, '0, 1'b0, 5);
    add_entry(OP_POLL, TMR_STAT_A, '0, 4'hF, 32'h1, 1'b0, 5);
    add_entry(OP_PINS, '0, '0, 4'h0, 32'h1_0FA5, 1'b0, 5);
    add_entry(OP_WR, TMR_CTRL_A, 32'h0, 4'h1, '0, 1'b0, 5);
    add_entry(OP_WR, TMR_STAT_A, 32'h1, 4'h1, '0, 1'b0, 5);
    add_entry(OP_RD, TMR_STAT_A, '0, 4'hF, 32'h0, 1'b0, 5);
    add_entry(OP_PINS, '0, '0, 4'h0, 32'h0FA5, 1'b0, 5);
    // Unmapped addresses and a mixed burst
    add_entry(OP_RD, GPIO_BASE + 32'h10, '0, 4'hF, '0, 1'b1, 6);
    add_entry(OP_WR, 32'h2000_0000, 32'h1, 4'hF, '0, 1'b1, 6);
    add_entry(OP_PIPE_WR, GPIO_OUT_A, 32'h3C, 4'h1, '0, 1'b0, 6);
    add_entry(OP_PIPE_RD, GPIO_OUT_A, '0, 4'hF, 32'h3C, 1'b0, 6);
    add_entry(OP_PIPE_RD, 32'h0000_0000, '0, 4'hF, '0, 1'b1, 6);
    add_entry(OP_PIPE_RD, TMR_CMP_A, '0, 4'hF, 32'h40, 1'b0, 6);
    add_entry(OP_PIPE_WR, TIMER_BASE + 32'h10, 32'h1, 4'hF, '0, 1'b1, 6);
    add_entry(OP_PIPE_RD, GPIO_DIR_A, '0, 4'hF, 32'h0F, 1'b0, 6);
    add_entry(OP_PINS, '0, '0, 4'h0, 32'h0F3C, 1'b0, 6);
  endtask

  task automatic report_test(input int test, input int test_errors);
    tests_run++;
    $display("test %0d finished with %0d errors", test, test_errors);
  endtask

  initial begin
    entry_t e;
    int     i;
    int     j;
    int     cur_test;
    int     err_base;
    reset_i   = 1'b1;
    wb_adr_i  = '0;
    wb_dat_i  = '0;
    wb_sel_i  = '0;
    wb_cyc_i  = 1'b0;
    wb_stb_i  = 1'b0;
    wb_we_i   = 1'b0;
    gpio_in_i = '0;
    errors    = 0;
    checks    = 0;
    tests_run = 0;
    build_table();
    repeat (4) @(posedge sys_clk);
    @(negedge sys_clk);
    reset_i  = 1'b0;
    cur_test = table_q[0].test;
    err_base = 0;
    i = 0;
    while (i < table_q.size()) begin
      e = table_q[i];
      if (e.test != cur_test) begin
        report_test(cur_test, errors - err_base);
        cur_test = e.test;
        err_base = errors;
      end
      if (is_pipe(e.op)) begin
        j = i;
        while (j + 1 < table_q.size() && is_pipe(table_q[j + 1].op)) begin
          j++;
        end
        run_burst(i, j);
        i = j + 1;
      end else begin
        apply_entry(e);
        i++;
      end
    end
    report_test(cur_test, errors - err_base);
    $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

//--- compile.f
src/soc_bus_pkg.sv
src/wb_if.sv
src/wb_gpio_port.sv
src/wb_timer.sv
src/wb_shared_bus.sv
src/periph_subsystem_top.sv
dv/periph_subsystem_props.sv
dv/tb_periph_subsystem.sv
